/* srt_pkg.sv */
`default_nettype none

package srt_pkg;

  // lanes and tags
  localparam int NUM_LANES = 4;
  localparam int LANE_W = 2;
  localparam int TAG_W = 3;

  // result queue
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW = 2;
  localparam int CNT_W = 3;   // holds 0..FIFO_DEPTH

  // radix-4 recurrence, two quotient bits per step
  localparam int ITERS = 14;
  localparam int ITER_CW = $clog2(ITERS + 1);
  localparam int QUO_W = 2 * ITERS;
  localparam int REM_W = 28;

  // apb word offsets
  localparam logic [7:0] ADDR_A = 8'h00;
  localparam logic [7:0] ADDR_B = 8'h04;
  localparam logic [7:0] ADDR_STATUS = 8'h08;
  localparam logic [7:0] ADDR_RESULT = 8'h0c;

  typedef enum logic [1:0] {
    SP_NORM = 2'd0,
    SP_ZERO = 2'd1,   // 0 / x
    SP_INF  = 2'd2    // x / 0
  } spec_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic              sign;
    logic signed [9:0] exp_diff;   // ea - eb + bias
    logic [23:0]       mant_a;
    logic [23:0]       mant_b;
    spec_t             special;
  } div_job_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic              sign;
    logic signed [9:0] exp_diff;
    spec_t             special;
    logic [QUO_W-1:0]  quot;
    logic              sticky;     // final remainder nonzero
  } lane_res_t;

endpackage

`default_nettype wire

/* fp_unpack.sv */
`default_nettype none

module fp_unpack (
  input  logic [31:0]               a,
  input  logic [31:0]               b,
  input  logic [srt_pkg::TAG_W-1:0] tag,
  output srt_pkg::div_job_t         job
);
  import srt_pkg::*;

  logic [7:0] exp_a;
  logic [7:0] exp_b;
  logic       a_zero;
  logic       b_zero;

  assign exp_a = a[30:23];
  assign exp_b = b[30:23];

  // zero exponent covers zero and denormal, both flushed
  assign a_zero = (exp_a == 8'd0);
  assign b_zero = (exp_b == 8'd0);

  always_comb begin
    job.tag = tag;
    job.sign = a[31] ^ b[31];
    job.exp_diff = $signed({2'b00, exp_a}) - $signed({2'b00, exp_b}) + 10'sd127;

    // hidden bit back in front of the fraction
    job.mant_a = a_zero ? 24'd0 : {1'b1, a[22:0]};
    job.mant_b = b_zero ? 24'd0 : {1'b1, b[22:0]};

    // divide by zero wins over zero dividend
    if (b_zero) begin
      job.special = SP_INF;
    end else if (a_zero) begin
      job.special = SP_ZERO;
    end else begin
      job.special = SP_NORM;
    end
  end

endmodule

`default_nettype wire

/* quo_sel_tab.sv */
`default_nettype none

// r_idx is 4w truncated to quarter units, d_idx the three fraction bits of d
module quo_sel_tab (
  input  logic signed [5:0] r_idx,
  input  logic [2:0]        d_idx,
  output logic signed [2:0] digit
);

  logic signed [5:0] m1;   // lower threshold for digit 1
  logic signed [5:0] m2;   // lower threshold for digit 2

  // thresholds in units of 1/4, one row per divisor interval of width 1/8
  always_comb begin
    case (d_idx)
      3'd0:    {m2, m1} = {6'sd6, 6'sd2};
      3'd1:    {m2, m1} = {6'sd7, 6'sd2};
      3'd2:    {m2, m1} = {6'sd8, 6'sd2};
      3'd3:    {m2, m1} = {6'sd8, 6'sd2};
      3'd4:    {m2, m1} = {6'sd9, 6'sd3};
      3'd5:    {m2, m1} = {6'sd10, 6'sd3};
      3'd6:    {m2, m1} = {6'sd11, 6'sd3};
      default: {m2, m1} = {6'sd11, 6'sd3};
    endcase
  end

  // negative side mirrors the positive thresholds
  always_comb begin
    if (r_idx >= m2) begin
      digit = 3'sd2;
    end else if (r_idx >= m1) begin
      digit = 3'sd1;
    end else if (r_idx >= -m1) begin
      digit = 3'sd0;
    end else if (r_idx >= -m2) begin
      digit = -3'sd1;
    end else begin
      digit = -3'sd2;
    end
  end

endmodule

`default_nettype wire

/* srt4_lane.sv */
`default_nettype none

module srt4_lane (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  srt_pkg::div_job_t  job,
  output logic               busy,
  output logic               done,
  input  logic               take,
  output srt_pkg::lane_res_t res
);
  import srt_pkg::*;

  div_job_t                job_q;
  logic [ITER_CW-1:0]      cnt;
  logic                    running;
  logic                    last;
  logic                    is_norm;

  logic signed [REM_W-1:0] rem;      // w scaled by 2^25
  logic signed [REM_W-1:0] dvs;      // d on the same scale
  logic signed [REM_W+1:0] rem4;
  logic signed [REM_W+1:0] dmul;
  logic signed [REM_W+1:0] rem_nx;
  logic signed [REM_W-1:0] rem_fin;
  logic                    rem_neg;

  logic signed [2:0]       digit;
  logic [1:0]              dig_lo;
  logic [1:0]              dig_m1;
  logic [QUO_W-1:0]        q_reg;
  logic [QUO_W-1:0]        qm_reg;   // always q_reg minus one ulp
  logic [QUO_W-1:0]        q_nx;
  logic [QUO_W-1:0]        qm_nx;
  logic [QUO_W-1:0]        quot_q;
  logic                    sticky_q;

  assign running = busy & ~done;
  assign last = (cnt == ITER_CW'(ITERS));   // correction step
  assign is_norm = (job_q.special == SP_NORM);

  assign dvs = {2'b00, job_q.mant_b, 2'b00};
  assign rem4 = {rem, 2'b00};

  quo_sel_tab u_qsel (
    .r_idx (rem[REM_W-2 -: 6]),
    .d_idx (job_q.mant_b[22:20]),
    .digit (digit)
  );

  // multiple of the divisor for |digit|
  always_comb begin
    case (digit)
      3'b010, 3'b110: dmul = {1'b0, dvs, 1'b0};
      3'b001, 3'b111: dmul = {2'b00, dvs};
      default:        dmul = '0;
    endcase
  end

  assign rem_nx = digit[2] ? rem4 + dmul : rem4 - dmul;

  // on-the-fly conversion, low two bits of q and q-1
  assign dig_lo = digit[1:0];
  assign dig_m1 = digit[1:0] - 2'd1;
  assign q_nx = (digit >= 3'sd0) ? {q_reg[QUO_W-3:0], dig_lo} : {qm_reg[QUO_W-3:0], dig_lo};
  assign qm_nx = (digit > 3'sd0) ? {q_reg[QUO_W-3:0], dig_m1} : {qm_reg[QUO_W-3:0], dig_m1};

  // negative remainder means the quotient is one ulp high
  assign rem_neg = rem[REM_W-1];
  assign rem_fin = rem_neg ? rem + dvs : rem;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt <= '0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      cnt <= '0;
    end else if (take) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (running) begin
      if (last) begin
        done <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      job_q <= job;
      rem <= REM_W'(job.mant_a);   // x/4 keeps the first digit in range
      q_reg <= '0;
      qm_reg <= '0;
    end else if (running && !last) begin
      if (is_norm) begin   // special jobs just count down
        rem <= rem_nx[REM_W-1:0];
        q_reg <= q_nx;
        qm_reg <= qm_nx;
      end
    end else if (running) begin
      quot_q <= rem_neg ? qm_reg : q_reg;
      sticky_q <= |rem_fin;
    end
  end

  always_comb begin
    res.tag = job_q.tag;
    res.sign = job_q.sign;
    res.exp_diff = job_q.exp_diff;
    res.special = job_q.special;
    res.quot = quot_q;
    res.sticky = sticky_q;
  end

endmodule

`default_nettype wire

/* apb_dispatch.sv */
`default_nettype none

module apb_dispatch (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [7:0]                    paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic [srt_pkg::NUM_LANES-1:0] busy,
  output logic [srt_pkg::NUM_LANES-1:0] start,
  output srt_pkg::div_job_t             job,
  input  logic [31:0]                   fifo_data,
  input  logic [srt_pkg::CNT_W-1:0]     fifo_count,
  output logic                          pop
);
  import srt_pkg::*;

  logic [31:0]          a_reg;
  logic [31:0]          b_reg;
  logic [TAG_W-1:0]     tag_q;
  logic [NUM_LANES-1:0] free;
  logic [NUM_LANES-1:0] pick;
  logic                 access;
  logic                 xfer;
  logic                 wr_a;
  logic                 wr_b;
  logic                 rd_res;
  logic                 addr_ok;
  logic                 fifo_empty;
  div_job_t             new_job;

  fp_unpack u_unpack (
    .a   (a_reg),
    .b   (pwdata),
    .tag (tag_q),
    .job (new_job)
  );

  // a lane with a start in flight is not free yet
  assign free = ~(busy | start);
  assign pick = free & (~free + NUM_LANES'(1));   // lowest free lane

  assign access = psel & penable;
  assign wr_a = access & pwrite & (paddr == ADDR_A);
  assign wr_b = access & pwrite & (paddr == ADDR_B);
  assign rd_res = ~pwrite & (paddr == ADDR_RESULT);
  assign addr_ok = (paddr == ADDR_A) | (paddr == ADDR_B) |
                   (paddr == ADDR_STATUS) | (paddr == ADDR_RESULT);
  assign fifo_empty = (fifo_count == '0);

  assign pready = access & ~(wr_b & ~|free);   // B waits for a lane
  assign xfer = access & pready;
  assign pslverr = xfer & (~addr_ok | (rd_res & fifo_empty));
  assign pop = xfer & rd_res & ~fifo_empty;

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        ADDR_A: prdata = a_reg;
        ADDR_B: prdata = b_reg;
        ADDR_STATUS: begin
          prdata[CNT_W-1:0] = fifo_count;
          prdata[8 +: NUM_LANES] = busy;
        end
        ADDR_RESULT: prdata = fifo_empty ? 32'd0 : fifo_data;
        default: prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      start <= '0;
      tag_q <= '0;
    end else begin
      start <= (xfer & wr_b) ? pick : '0;
      if (xfer && wr_b) tag_q <= tag_q + 1'b1;   // wraps mod 8
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && wr_a) a_reg <= pwdata;
    if (xfer && wr_b) begin
      b_reg <= pwdata;
      job <= new_job;
    end
  end

endmodule

`default_nettype wire

/* result_collect.sv */
`default_nettype none

module result_collect (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [srt_pkg::NUM_LANES-1:0] done,
  input  srt_pkg::lane_res_t            res [srt_pkg::NUM_LANES],
  output logic [srt_pkg::NUM_LANES-1:0] take,
  input  logic                          pop,
  output logic [31:0]                   fifo_data,
  output logic [srt_pkg::CNT_W-1:0]     fifo_count
);
  import srt_pkg::*;

  logic [TAG_W-1:0]   exp_tag;
  logic               hit;
  logic [LANE_W-1:0]  hit_idx;
  logic               room;
  logic               take_vld;
  logic [LANE_W-1:0]  take_idx;
  lane_res_t          cur;
  logic [23:0]        mant;
  logic               guard;
  logic               rnd;
  logic               stk;
  logic               rnd_up;
  logic [24:0]        mant_r;
  logic signed [9:0]  exp_n;
  logic signed [9:0]  exp_r;
  logic [31:0]        res_word;
  logic [31:0]        mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;

  // only the lane holding the next tag in sequence
  always_comb begin
    hit = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (done[i] && res[i].tag == exp_tag) begin
        hit = 1'b1;
        hit_idx = LANE_W'(i);
      end
    end
  end

  assign room = (int'(fifo_count) + int'(take_vld)) < FIFO_DEPTH;   // count the pending write
  assign take = take_vld ? NUM_LANES'(1) << take_idx : '0;
  assign cur = res[take_idx];

  // normalize to 24 bits, leading one at bit 26 or 25
  always_comb begin
    if (cur.quot[QUO_W-2]) begin
      mant = cur.quot[QUO_W-2 -: 24];
      guard = cur.quot[2];
      rnd = cur.quot[1];
      stk = cur.quot[0] | cur.sticky;
      exp_n = cur.exp_diff;
    end else begin
      mant = cur.quot[QUO_W-3 -: 24];
      guard = cur.quot[1];
      rnd = cur.quot[0];
      stk = cur.sticky;
      exp_n = cur.exp_diff - 10'sd1;
    end
    rnd_up = guard & (rnd | stk | mant[0]);   // ties go to even
    mant_r = {1'b0, mant} + 25'(rnd_up);
    exp_r = mant_r[24] ? exp_n + 10'sd1 : exp_n;   // rounding carried out
  end

  always_comb begin
    case (cur.special)
      SP_ZERO: res_word = {cur.sign, 31'd0};
      SP_INF:  res_word = {cur.sign, 8'hff, 23'd0};
      default: begin
        if (exp_r >= 10'sd255) begin
          res_word = {cur.sign, 8'hff, 23'd0};
        end else if (exp_r < 10'sd1) begin
          res_word = {cur.sign, 31'd0};
        end else begin
          res_word = {cur.sign, exp_r[7:0], mant_r[22:0]};
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      take_vld <= 1'b0;
      take_idx <= '0;
      exp_tag <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      fifo_count <= '0;
    end else begin
      take_vld <= hit & room;
      if (hit && room) begin
        take_idx <= hit_idx;
        exp_tag <= exp_tag + 1'b1;
      end
      if (take_vld) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      fifo_count <= fifo_count + CNT_W'(take_vld) - CNT_W'(pop);
    end
  end

  // result written while the lane still holds it
  always_ff @(posedge clk) begin
    if (take_vld) mem[wr_ptr] <= res_word;
  end

  assign fifo_data = mem[rd_ptr];

endmodule

`default_nettype wire

/* srt_div_top.sv */
`default_nettype none

module srt_div_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import srt_pkg::*;

  logic [NUM_LANES-1:0] busy;
  logic [NUM_LANES-1:0] start;
  logic [NUM_LANES-1:0] done;
  logic [NUM_LANES-1:0] take;
  div_job_t             job;
  lane_res_t            lane_res [NUM_LANES];
  logic [31:0]          fifo_data;
  logic [CNT_W-1:0]     fifo_count;
  logic                 pop;

  apb_dispatch u_disp (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .busy       (busy),
    .start      (start),
    .job        (job),
    .fifo_data  (fifo_data),
    .fifo_count (fifo_count),
    .pop        (pop)
  );

  // job is broadcast, start picks the lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    srt4_lane u_lane (
      .clk   (clk),
      .rst   (rst),
      .start (start[i]),
      .job   (job),
      .busy  (busy[i]),
      .done  (done[i]),
      .take  (take[i]),
      .res   (lane_res[i])
    );
  end

  result_collect u_coll (
    .clk        (clk),
    .rst        (rst),
    .done       (done),
    .res        (lane_res),
    .take       (take),
    .pop        (pop),
    .fifo_data  (fifo_data),
    .fifo_count (fifo_count)
  );

endmodule

`default_nettype wire

/* srt_div_assert.sv */
`default_nettype none

module srt_div_assert (
  input logic                          clk,
  input logic                          rst,
  input logic [srt_pkg::NUM_LANES-1:0] start,
  input logic [srt_pkg::NUM_LANES-1:0] busy,
  input logic [srt_pkg::NUM_LANES-1:0] done,
  input logic [srt_pkg::NUM_LANES-1:0] take,
  input logic [srt_pkg::CNT_W-1:0]     fifo_count
);
  import srt_pkg::*;

  a_start_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(start))
    else $error("start drives more than one lane");

  a_start_free: assert property (@(posedge clk) disable iff (!rst) (start & busy) == '0)
    else $error("start issued to a busy lane");

  a_take_done: assert property (@(posedge clk) disable iff (!rst) (take & ~done) == '0)
    else $error("take on a lane that is not done");

  a_fifo_bound: assert property (@(posedge clk) disable iff (!rst)
                                 fifo_count <= CNT_W'(FIFO_DEPTH))
    else $error("fifo_count above queue depth");

  // load, iterations and correction
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lat
    a_latency: assert property (@(posedge clk) disable iff (!rst)
                                $past(start[i], ITERS + 2) |-> done[i])
      else $error("lane %0d not done 16 cycles after start", i);

    a_not_early: assert property (@(posedge clk) disable iff (!rst)
                                  $past(start[i], ITERS + 1) |-> !done[i])
      else $error("lane %0d done before 16 cycles after start", i);
  end

endmodule

`default_nettype wire

/* tb_srt_div.sv */
`default_nettype none

module tb_srt_div;
  import srt_pkg::*;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int seed;
  int checks;
  int errors;

  srt_div_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  bind srt_div_top srt_div_assert u_chk (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .take       (take),
    .fifo_count (fifo_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("timeout at %0t, %s", $time, what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic apply_reset();
    rst = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b1;
  endtask

  // enters and leaves 2 units after a rising edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err, output int waits);
    int   n;
    logic got;
    n = 0;
    got = 1'b0;
    rdata = '0;
    err = 1'b0;
    waits = 0;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    while (!got && n < 200) begin
      @(negedge clk);   // pready settled mid-cycle
      if (pready) begin
        got = 1'b1;
        rdata = prdata;
        err = pslverr;
      end else begin
        waits++;
      end
      @(posedge clk);
      #2;
      n++;
    end
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    if (!got) begin
      abort_on_timeout($sformatf("no pready for APB access to 0x%02h", addr));
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           output logic err, output int waits);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err, waits);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    int waits;
    apb_xfer(1'b0, addr, 32'd0, data, err, waits);
  endtask

  // poll STATUS until the result queue holds something
  task automatic wait_result(input string what);
    logic [31:0] st;
    logic        err;
    int          n;
    n = 0;
    st = '0;
    while (st[2:0] == 3'd0 && n < 200) begin
      read_reg(ADDR_STATUS, st, err);
      n++;
    end
    if (st[2:0] == 3'd0) begin
      abort_on_timeout({"result never arrived for ", what});
    end
  endtask

  // integer reference model with the quotient scaled by 2^26
  function automatic logic [31:0] ref_div(input logic [31:0] a, input logic [31:0] b);
    logic        s;
    int          e;
    logic [49:0] num;
    logic [49:0] q;
    logic [49:0] r;
    logic [49:0] mant;
    int          tail;
    int          half;
    s = a[31] ^ b[31];
    if (b[30:23] == 8'd0) return {s, 8'hff, 23'd0};
    if (a[30:23] == 8'd0) return {s, 31'd0};
    num = 50'({1'b1, a[22:0]}) << 26;
    q = num / 50'({1'b1, b[22:0]});
    r = num % 50'({1'b1, b[22:0]});
    e = int'(a[30:23]) - int'(b[30:23]) + 127;
    if (q >= (50'd1 << 26)) begin
      mant = q >> 3;
      tail = int'(q[2:0]);
      half = 4;
    end else begin
      mant = q >> 2;   // quotient below one
      tail = int'(q[1:0]);
      half = 2;
      e = e - 1;
    end
    if (tail > half || (tail == half && (r != 0 || mant[0]))) mant = mant + 50'd1;
    if (mant == (50'd1 << 24)) begin
      mant = mant >> 1;
      e = e + 1;
    end
    if (e >= 255) return {s, 8'hff, 23'd0};
    if (e < 1) return {s, 31'd0};
    return {s, 8'(e), mant[22:0]};
  endfunction

  function automatic logic [31:0] rand_norm(input int spread);
    logic [31:0] r;
    int          e;
    r = $random(seed);
    e = 127 + ($random(seed) % spread);
    return {r[31], 8'(e), r[22:0]};
  endfunction

  // quotient a few ulps around the midpoint of two results
  task automatic make_near_tie(input logic above, output logic [31:0] a, output logic [31:0] b);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [23:0] mb;
    logic [24:0] c;
    logic [48:0] p;
    logic [23:0] ma;
    r1 = $random(seed);
    r2 = $random(seed);
    mb = {2'b11, r1[21:0]};
    c = {2'b11, r2[22:1], 1'b1};   // odd so c/2^25 sits on a tie
    p = 49'(c) * 49'(mb);
    ma = p[48:25];
    if (above && ma != 24'hffffff) ma = ma + 24'd1;
    a = {r1[31], 8'd127, ma[22:0]};
    b = {r2[31], 8'd126 + {7'd0, r2[0]}, mb[22:0]};
  endtask

  task automatic run_div(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rd;
    logic        err;
    int          w;
    string       tag;
    tag = $sformatf("%08h/%08h", a, b);
    write_reg(ADDR_A, a, err, w);
    check({"pslverr write A ", tag}, 32'd0, {31'd0, err});
    check({"wait states A ", tag}, 32'd0, 32'(w));
    write_reg(ADDR_B, b, err, w);
    check({"pslverr write B ", tag}, 32'd0, {31'd0, err});
    check({"wait states B ", tag}, 32'd0, 32'(w));
    wait_result(tag);
    read_reg(ADDR_RESULT, rd, err);
    check({"pslverr RESULT ", tag}, 32'd0, {31'd0, err});
    check({"prdata RESULT ", tag}, ref_div(a, b), rd);
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("test %s finished: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic single_divs();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    repeat (200) run_div(rand_norm(8), rand_norm(8));
    report_test("single_div", c0, e0);
  endtask

  task automatic rounding_ties();
    logic [31:0] a;
    logic [31:0] b;
    int          c0;
    int          e0;
    c0 = checks;
    e0 = errors;
    run_div(32'h40c00000, 32'h40400000);   // 6 / 3 exact
    run_div(32'h3f800000, 32'h3f800000);
    run_div(32'h40f00000, 32'h40200000);   // 7.5 / 2.5
    run_div(32'hc1200000, 32'h40800000);
    run_div(32'h3fffffff, 32'h3f800001);   // close to 2
    run_div(32'h3f800000, 32'h3f800001);   // just under 1
    for (int i = 0; i < 12; i++) begin
      make_near_tie(1'b0, a, b);
      run_div(a, b);
      make_near_tie(1'b1, a, b);
      run_div(a, b);
    end
    report_test("rounding", c0, e0);
  endtask

  task automatic specials_range();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    run_div(32'h00000000, rand_norm(8));
    run_div(32'h80000000, 32'h40400000);   // signed zero
    run_div(32'h40400000, 32'h00000000);
    run_div(32'hc0400000, 32'h00000000);
    run_div(32'h00012345, 32'h3f800000);   // denormal dividend flushed
    run_div(32'h3f800000, 32'h80400000);   // denormal divisor flushed
    run_div(32'h7d000000, 32'h02800000);   // far overflow
    run_div(32'h02800000, 32'h7d000000);   // far underflow
    run_div(32'h7f000000, 32'h3f7fffff);   // largest exponent yet finite
    run_div(32'h7f400000, 32'h3f000000);   // one step past
    run_div(32'h00800000, 32'h3f800000);   // smallest normal
    run_div(32'h00800000, 32'h3fc00000);
    report_test("special_range", c0, e0);
  endtask

  task automatic burst_in_order();
    logic [31:0] a_q [8];
    logic [31:0] b_q [8];
    logic [31:0] rd;
    logic        err;
    int          w;
    int          max_w;
    int          c0;
    int          e0;
    c0 = checks;
    e0 = errors;
    max_w = 0;
    for (int i = 0; i < 8; i++) begin
      a_q[i] = rand_norm(8);
      b_q[i] = rand_norm(8);
      write_reg(ADDR_A, a_q[i], err, w);
      write_reg(ADDR_B, b_q[i], err, w);
      if (w > max_w) max_w = w;
    end
    check("pready stall on B write", 32'd1, {31'd0, max_w > 0});
    // results must come back in write order
    for (int i = 0; i < 8; i++) begin
      wait_result($sformatf("burst job %0d", i));
      read_reg(ADDR_RESULT, rd, err);
      check($sformatf("pslverr RESULT burst %0d", i), 32'd0, {31'd0, err});
      check($sformatf("prdata RESULT burst %0d", i), ref_div(a_q[i], b_q[i]), rd);
    end
    report_test("burst_order", c0, e0);
  endtask

  task automatic reg_errors();
    logic [31:0] rd;
    logic        err;
    int          w;
    int          c0;
    int          e0;
    c0 = checks;
    e0 = errors;
    apply_reset();
    read_reg(ADDR_STATUS, rd, err);
    check("STATUS fifo_count", 32'd0, {29'd0, rd[2:0]});
    check("STATUS busy", 32'd0, {28'd0, rd[11:8]});
    check("pslverr STATUS", 32'd0, {31'd0, err});
    read_reg(ADDR_RESULT, rd, err);
    check("prdata empty RESULT", 32'd0, rd);
    check("pslverr empty RESULT", 32'd1, {31'd0, err});
    read_reg(8'h10, rd, err);
    check("pslverr unknown read", 32'd1, {31'd0, err});
    write_reg(8'h14, 32'h0000_1234, err, w);
    check("pslverr unknown write", 32'd1, {31'd0, err});
    report_test("registers", c0, e0);
  endtask

  initial begin
    seed = 32'h90b7_f5d7;
    checks = 0;
    errors = 0;
    rst = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 8'd0;
    pwdata = 32'd0;
    apply_reset();
    single_divs();
    rounding_ties();
    specials_range();
    burst_in_order();
    reg_errors();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
srt_pkg.sv
fp_unpack.sv
quo_sel_tab.sv
srt4_lane.sv
apb_dispatch.sv
result_collect.sv
srt_div_top.sv
srt_div_assert.sv
tb_srt_div.sv

/* run.sh */
#!/bin/sh
# build and run the divider testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_srt_div -o tb_srt_div
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_srt_div > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
